/* mips_lite.f */
rtl/mips_lite_pkg.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/write_back.sv
rtl/mips_lite_top.sv
tests/clock_gen.sv
tests/tb_mips_lite.sv

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
   input  logic                                  i_clock,
   input  logic                                  i_reset,
   input  logic                                  i_valid,
   input  logic                                  i_we,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rs,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rt,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rd,
   input  mips_lite_pkg::alu_op_e                i_alu_op,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_imm,
   input  logic                                  i_use_imm,
   input  logic [mips_lite_pkg::NB_SHAMT-1:0]    i_shamt,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_rs_data,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_rt_data,
   input  logic                                  i_wb_we,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_wb_addr,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_wb_data,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rs_addr,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rt_addr,
   output logic                                  o_valid,
   output logic                                  o_we,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rd,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_result
);

   logic                             ex_write;
   logic                             ex_hit_rs;
   logic                             ex_hit_rt;
   logic                             wb_hit_rs;
   logic                             wb_hit_rt;
   logic [mips_lite_pkg::NB_REG-1:0] rs_value;
   logic [mips_lite_pkg::NB_REG-1:0] rt_value;
   logic [mips_lite_pkg::NB_REG-1:0] operand_a;
   logic [mips_lite_pkg::NB_REG-1:0] operand_b;
   logic [mips_lite_pkg::NB_REG-1:0] alu_result;

   // Register file read addresses come straight from decode
   assign o_rs_addr = i_rs;
   assign o_rt_addr = i_rt;

   // Forwarding, own result register first, then write-back
   assign ex_write  = o_valid && o_we;
   assign ex_hit_rs = ex_write && (o_rd == i_rs) && (i_rs != '0);
   assign ex_hit_rt = ex_write && (o_rd == i_rt) && (i_rt != '0);
   assign wb_hit_rs = i_wb_we && (i_wb_addr == i_rs) && (i_rs != '0);
   assign wb_hit_rt = i_wb_we && (i_wb_addr == i_rt) && (i_rt != '0);

   always_comb begin
      if (ex_hit_rs) begin
         rs_value = o_result;
      end else if (wb_hit_rs) begin
         rs_value = i_wb_data;
      end else begin
         rs_value = i_rs_data;
      end
      if (ex_hit_rt) begin
         rt_value = o_result;
      end else if (wb_hit_rt) begin
         rt_value = i_wb_data;
      end else begin
         rt_value = i_rt_data;
      end
   end

   assign operand_a = rs_value;
   assign operand_b = i_use_imm ? i_imm : rt_value;

   always_comb begin
      case (i_alu_op)
         mips_lite_pkg::ALU_ADD: alu_result = operand_a + operand_b;
         mips_lite_pkg::ALU_SUB: alu_result = operand_a - operand_b;
         mips_lite_pkg::ALU_AND: alu_result = operand_a & operand_b;
         mips_lite_pkg::ALU_OR:  alu_result = operand_a | operand_b;
         mips_lite_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
         mips_lite_pkg::ALU_NOR: alu_result = ~(operand_a | operand_b);
         mips_lite_pkg::ALU_SLT: begin
            alu_result = {{(mips_lite_pkg::NB_REG-1){1'b0}},
                          ($signed(operand_a) < $signed(operand_b))};
         end
         // Shifts act on rt
         mips_lite_pkg::ALU_SLL: alu_result = operand_b << i_shamt;
         mips_lite_pkg::ALU_SRL: alu_result = operand_b >> i_shamt;
         mips_lite_pkg::ALU_LUI: alu_result = operand_b;
         default:                alu_result = '0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_valid <= 1'b0;
         o_we    <= 1'b0;
      end else begin
         o_valid <= i_valid;
         o_we    <= i_valid && i_we;
      end
   end

   always_ff @(posedge i_clock) begin
      o_rd     <= i_rd;
      o_result <= alu_result;
   end

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
   input  logic                                  i_clock,
   input  logic                                  i_reset,
   input  logic                                  i_instr_valid,
   input  logic [mips_lite_pkg::NB_INSTR-1:0]    i_instr,
   output logic                                  o_valid,
   output logic                                  o_we,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rs,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rt,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_rd,
   output mips_lite_pkg::alu_op_e                o_alu_op,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_imm,
   output logic                                  o_use_imm,
   output logic [mips_lite_pkg::NB_SHAMT-1:0]    o_shamt
);

   mips_lite_pkg::opcode_e                opcode;
   mips_lite_pkg::funct_e                 funct;
   logic [mips_lite_pkg::NB_IMM-1:0]      imm_field;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] rs_field;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] rt_field;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] rd_field;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] dest;
   mips_lite_pkg::alu_op_e                alu_op;
   logic [mips_lite_pkg::NB_REG-1:0]      imm_ext;
   logic                                  use_imm;
   logic                                  supported;

   assign opcode    = mips_lite_pkg::opcode_e'(i_instr[mips_lite_pkg::MSB_OPCODE -:
                                                        mips_lite_pkg::NB_OPCODE]);
   assign funct     = mips_lite_pkg::funct_e'(i_instr[mips_lite_pkg::NB_FUNCT-1:0]);
   assign imm_field = i_instr[mips_lite_pkg::NB_IMM-1:0];
   assign rs_field  = i_instr[mips_lite_pkg::MSB_RS -: mips_lite_pkg::NB_REG_ADDR];
   assign rt_field  = i_instr[mips_lite_pkg::MSB_RT -: mips_lite_pkg::NB_REG_ADDR];
   assign rd_field  = i_instr[mips_lite_pkg::MSB_RD -: mips_lite_pkg::NB_REG_ADDR];

   always_comb begin
      alu_op    = mips_lite_pkg::ALU_ADD;
      imm_ext   = {{(mips_lite_pkg::NB_REG-mips_lite_pkg::NB_IMM){imm_field[15]}}, imm_field};
      use_imm   = 1'b1;
      dest      = rt_field;
      supported = 1'b1;
      case (opcode)
         mips_lite_pkg::OP_RTYPE: begin
            use_imm = 1'b0;
            dest    = rd_field;
            case (funct)
               mips_lite_pkg::F_SLL: alu_op = mips_lite_pkg::ALU_SLL;
               mips_lite_pkg::F_SRL: alu_op = mips_lite_pkg::ALU_SRL;
               mips_lite_pkg::F_ADD: alu_op = mips_lite_pkg::ALU_ADD;
               mips_lite_pkg::F_SUB: alu_op = mips_lite_pkg::ALU_SUB;
               mips_lite_pkg::F_AND: alu_op = mips_lite_pkg::ALU_AND;
               mips_lite_pkg::F_OR:  alu_op = mips_lite_pkg::ALU_OR;
               mips_lite_pkg::F_XOR: alu_op = mips_lite_pkg::ALU_XOR;
               mips_lite_pkg::F_NOR: alu_op = mips_lite_pkg::ALU_NOR;
               mips_lite_pkg::F_SLT: alu_op = mips_lite_pkg::ALU_SLT;
               default:              supported = 1'b0;
            endcase
         end
         mips_lite_pkg::OP_ADDI: alu_op = mips_lite_pkg::ALU_ADD;
         mips_lite_pkg::OP_SLTI: alu_op = mips_lite_pkg::ALU_SLT;
         mips_lite_pkg::OP_ANDI: begin
            alu_op  = mips_lite_pkg::ALU_AND;
            imm_ext = {{(mips_lite_pkg::NB_REG-mips_lite_pkg::NB_IMM){1'b0}}, imm_field};
         end
         mips_lite_pkg::OP_ORI: begin
            alu_op  = mips_lite_pkg::ALU_OR;
            imm_ext = {{(mips_lite_pkg::NB_REG-mips_lite_pkg::NB_IMM){1'b0}}, imm_field};
         end
         mips_lite_pkg::OP_XORI: begin
            alu_op  = mips_lite_pkg::ALU_XOR;
            imm_ext = {{(mips_lite_pkg::NB_REG-mips_lite_pkg::NB_IMM){1'b0}}, imm_field};
         end
         mips_lite_pkg::OP_LUI: begin
            alu_op  = mips_lite_pkg::ALU_LUI;
            imm_ext = {imm_field, {(mips_lite_pkg::NB_REG-mips_lite_pkg::NB_IMM){1'b0}}};
         end
         default: supported = 1'b0;
      endcase
   end

   // Invalid or unsupported slots travel on as bubbles
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_valid <= 1'b0;
         o_we    <= 1'b0;
      end else begin
         o_valid <= i_instr_valid;
         o_we    <= i_instr_valid && supported && (dest != '0);
      end
   end

   always_ff @(posedge i_clock) begin
      o_rs      <= rs_field;
      o_rt      <= rt_field;
      o_rd      <= dest;
      o_alu_op  <= alu_op;
      o_imm     <= imm_ext;
      o_use_imm <= use_imm;
      o_shamt   <= i_instr[mips_lite_pkg::MSB_SHAMT -: mips_lite_pkg::NB_SHAMT];
   end

endmodule

/* rtl/mips_lite_pkg.sv */
package mips_lite_pkg;

   // Datapath widths
   localparam int NB_REG      = 32;
   localparam int NB_INSTR    = 32;
   localparam int NB_REG_ADDR = 5;
   localparam int NB_IMM      = 16;
   localparam int NB_SHAMT    = 5;
   localparam int NB_OPCODE   = 6;
   localparam int NB_FUNCT    = 6;
   localparam int NB_ALU_OP   = 4;
   localparam int N_REGS      = 32;

   // Top bit of each instruction field
   localparam int MSB_OPCODE  = 31;
   localparam int MSB_RS      = 25;
   localparam int MSB_RT      = 20;
   localparam int MSB_RD      = 15;
   localparam int MSB_SHAMT   = 10;

   // Major opcodes, standard MIPS encoding
   typedef enum logic [NB_OPCODE-1:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08,
      OP_SLTI  = 6'h0a,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f
   } opcode_e;

   // R-type function field
   typedef enum logic [NB_FUNCT-1:0] {
      F_SLL = 6'h00,
      F_SRL = 6'h02,
      F_ADD = 6'h20,
      F_SUB = 6'h22,
      F_AND = 6'h24,
      F_OR  = 6'h25,
      F_XOR = 6'h26,
      F_NOR = 6'h27,
      F_SLT = 6'h2a
   } funct_e;

   typedef enum logic [NB_ALU_OP-1:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_NOR = 4'd5,
      ALU_SLT = 4'd6,
      ALU_SLL = 4'd7,
      ALU_SRL = 4'd8,
      // Passes operand B, immediate already in the upper half
      ALU_LUI = 4'd9
   } alu_op_e;

endpackage

/* rtl/mips_lite_top.sv */
`timescale 1ns/1ps

module mips_lite_top (
   input  logic                                  i_clock,
   input  logic                                  i_reset,
   input  logic                                  i_instr_valid,
   input  logic [mips_lite_pkg::NB_INSTR-1:0]    i_instr,
   output logic                                  o_wb_valid,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_wb_addr,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_wb_data
);

   // Decode to execute
   logic                                  dec_valid;
   logic                                  dec_we;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] dec_rs;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] dec_rt;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] dec_rd;
   mips_lite_pkg::alu_op_e                dec_alu_op;
   logic [mips_lite_pkg::NB_REG-1:0]      dec_imm;
   logic                                  dec_use_imm;
   logic [mips_lite_pkg::NB_SHAMT-1:0]    dec_shamt;

   // Register file read side
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] rf_rs_addr;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] rf_rt_addr;
   logic [mips_lite_pkg::NB_REG-1:0]      rf_rs_data;
   logic [mips_lite_pkg::NB_REG-1:0]      rf_rt_data;

   // Execute to write-back
   logic                                  ex_valid;
   logic                                  ex_we;
   logic [mips_lite_pkg::NB_REG_ADDR-1:0] ex_rd;
   logic [mips_lite_pkg::NB_REG-1:0]      ex_result;

   instr_decode u_instr_decode (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_valid       (dec_valid),
      .o_we          (dec_we),
      .o_rs          (dec_rs),
      .o_rt          (dec_rt),
      .o_rd          (dec_rd),
      .o_alu_op      (dec_alu_op),
      .o_imm         (dec_imm),
      .o_use_imm     (dec_use_imm),
      .o_shamt       (dec_shamt)
   );

   register_file u_register_file (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_rs_addr (rf_rs_addr),
      .i_rt_addr (rf_rt_addr),
      .i_we      (o_wb_valid),
      .i_wr_addr (o_wb_addr),
      .i_wr_data (o_wb_data),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   execute_stage u_execute_stage (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_valid   (dec_valid),
      .i_we      (dec_we),
      .i_rs      (dec_rs),
      .i_rt      (dec_rt),
      .i_rd      (dec_rd),
      .i_alu_op  (dec_alu_op),
      .i_imm     (dec_imm),
      .i_use_imm (dec_use_imm),
      .i_shamt   (dec_shamt),
      .i_rs_data (rf_rs_data),
      .i_rt_data (rf_rt_data),
      .i_wb_we   (o_wb_valid),
      .i_wb_addr (o_wb_addr),
      .i_wb_data (o_wb_data),
      .o_rs_addr (rf_rs_addr),
      .o_rt_addr (rf_rt_addr),
      .o_valid   (ex_valid),
      .o_we      (ex_we),
      .o_rd      (ex_rd),
      .o_result  (ex_result)
   );

   write_back u_write_back (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_valid   (ex_valid),
      .i_we      (ex_we),
      .i_rd      (ex_rd),
      .i_result  (ex_result),
      .o_wb_we   (o_wb_valid),
      .o_wb_addr (o_wb_addr),
      .o_wb_data (o_wb_data)
   );

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
   input  logic                                  i_clock,
   input  logic                                  i_reset,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rs_addr,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rt_addr,
   input  logic                                  i_we,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_wr_addr,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_wr_data,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_rs_data,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_rt_data
);

   logic [mips_lite_pkg::NB_REG-1:0] regs [0:mips_lite_pkg::N_REGS-1];

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         for (int i = 0; i < mips_lite_pkg::N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we && (i_wr_addr != '0)) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // Register 0 is hardwired to zero
   assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
   assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule

/* rtl/write_back.sv */
`timescale 1ns/1ps

module write_back (
   input  logic                                  i_clock,
   input  logic                                  i_reset,
   input  logic                                  i_valid,
   input  logic                                  i_we,
   input  logic [mips_lite_pkg::NB_REG_ADDR-1:0] i_rd,
   input  logic [mips_lite_pkg::NB_REG-1:0]      i_result,
   output logic                                  o_wb_we,
   output logic [mips_lite_pkg::NB_REG_ADDR-1:0] o_wb_addr,
   output logic [mips_lite_pkg::NB_REG-1:0]      o_wb_data
);

   // Only a valid slot that writes raises the enable
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_wb_we <= 1'b0;
      end else begin
         o_wb_we <= i_valid && i_we;
      end
   end

   always_ff @(posedge i_clock) begin
      o_wb_addr <= i_rd;
      o_wb_data <= i_result;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_mips_lite -f mips_lite.f \
   && ./obj_dir/Vtb_mips_lite > sim.log 2>&1 \
   || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qx "all tests passed" sim.log 2>/dev/null \
   && echo "PASS" && exit 0 \
   || { echo "FAIL"; exit 1; }

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
   output logic o_clock,
   output logic o_reset
);

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 3;

   initial begin
      o_clock = 1'b0;
      forever #(HALF_PERIOD) o_clock = ~o_clock;
   end

   // Reset covers the first three rising edges
   initial begin
      o_reset <= 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clock);
      o_reset <= 1'b0;
   end

endmodule

/* tests/tb_mips_lite.sv */
`timescale 1ns/1ps

module tb_mips_lite;

   localparam int N_SLOTS       = 2000;
   localparam int DEPTH         = 4;
   localparam int LATENCY       = 3;
   localparam int RESET_TIMEOUT = 20;
   localparam int DRAIN_TIMEOUT = 20;

   typedef logic [mips_lite_pkg::NB_REG-1:0]      word_t;
   typedef logic [mips_lite_pkg::NB_REG_ADDR-1:0] reg_idx_t;
   typedef logic [mips_lite_pkg::NB_SHAMT-1:0]    shamt_t;
   typedef logic [1:0]                            slot_t;

   logic     clock;
   logic     reset;
   logic     instr_valid;
   word_t    instr;
   logic     wb_valid;
   reg_idx_t wb_addr;
   word_t    wb_data;

   // Reference state
   word_t    model_regs [0:mips_lite_pkg::N_REGS-1];
   logic     exp_valid  [0:DEPTH-1];
   reg_idx_t exp_addr   [0:DEPTH-1];
   word_t    exp_data   [0:DEPTH-1];
   word_t    rng_state;
   int       cycle;
   int       outstanding;
   int       n_writes;

   clock_gen u_clock_gen (
      .o_clock (clock),
      .o_reset (reset)
   );

   mips_lite_top uut (
      .i_clock       (clock),
      .i_reset       (reset),
      .i_instr_valid (instr_valid),
      .i_instr       (instr),
      .o_wb_valid    (wb_valid),
      .o_wb_addr     (wb_addr),
      .o_wb_data     (wb_data)
   );

   function automatic word_t next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int pick(input int n);
      word_t r;
      r = next_random();
      return int'(r[31:16]) % n;
   endfunction

   task automatic report_mismatch(input string name, input word_t expected,
                                  input word_t actual);
      $display("FAIL time %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("tests failed");
      $fatal(1, "output mismatch");
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at time %0t: %s", $time, what);
      $display("tests failed");
      $fatal(1, "simulation timed out");
   endtask

   // Builds one random slot and executes it on the reference registers
   task automatic build_slot(input logic active, output logic valid, output word_t word,
                             output logic we, output reg_idx_t dest, output word_t value);
      int       kind;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      shamt_t   shamt;
      logic [mips_lite_pkg::NB_IMM-1:0] imm;
      word_t    r;
      word_t    a;
      word_t    b;
      word_t    imm_s;
      word_t    imm_z;
      valid = (pick(10) >= 2) && active;
      kind  = pick(16);
      rs    = reg_idx_t'(pick(8));
      rt    = reg_idx_t'(pick(8));
      rd    = reg_idx_t'(pick(8));
      shamt = shamt_t'(pick(32));
      r     = next_random();
      imm   = r[23:8];
      a     = model_regs[rs];
      b     = model_regs[rt];
      imm_s = {{16{imm[15]}}, imm};
      imm_z = {16'h0000, imm};
      we    = 1'b1;
      dest  = rd;
      value = '0;
      case (kind)
         0: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_ADD};
            value = a + b;
         end
         1: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_SUB};
            value = a - b;
         end
         2: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_AND};
            value = a & b;
         end
         3: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_OR};
            value = a | b;
         end
         4: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_XOR};
            value = a ^ b;
         end
         5: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_NOR};
            value = ~(a | b);
         end
         6: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, mips_lite_pkg::F_SLT};
            value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         end
         7: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, shamt, mips_lite_pkg::F_SLL};
            value = b << shamt;
         end
         8: begin
            word  = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, shamt, mips_lite_pkg::F_SRL};
            value = b >> shamt;
         end
         9: begin
            word  = {mips_lite_pkg::OP_ADDI, rs, rt, imm};
            dest  = rt;
            value = a + imm_s;
         end
         10: begin
            word  = {mips_lite_pkg::OP_SLTI, rs, rt, imm};
            dest  = rt;
            value = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
         end
         11: begin
            word  = {mips_lite_pkg::OP_ANDI, rs, rt, imm};
            dest  = rt;
            value = a & imm_z;
         end
         12: begin
            word  = {mips_lite_pkg::OP_ORI, rs, rt, imm};
            dest  = rt;
            value = a | imm_z;
         end
         13: begin
            word  = {mips_lite_pkg::OP_XORI, rs, rt, imm};
            dest  = rt;
            value = a ^ imm_z;
         end
         14: begin
            word  = {mips_lite_pkg::OP_LUI, 5'd0, rt, imm};
            dest  = rt;
            value = {imm, 16'h0000};
         end
         default: begin
            // Unsupported load opcode or jr function
            if (imm[0]) begin
               word = {mips_lite_pkg::OP_RTYPE, rs, rt, rd, 5'd0, 6'h08};
            end else begin
               word = {6'h23, rs, rt, imm};
            end
            we = 1'b0;
         end
      endcase
      if (!valid || dest == '0) begin
         we = 1'b0;
      end
      if (we) begin
         model_regs[dest] = value;
      end
   endtask

   task automatic issue_slot(input logic active);
      logic     valid;
      word_t    word;
      logic     we;
      reg_idx_t dest;
      word_t    value;
      slot_t    slot;
      build_slot(active, valid, word, we, dest, value);
      cycle++;
      slot = slot_t'(cycle % DEPTH);
      instr_valid <= valid;
      instr       <= word;
      exp_valid[slot] = we;
      exp_addr[slot]  = dest;
      exp_data[slot]  = value;
      if (we) begin
         outstanding++;
         n_writes++;
      end
   endtask

   task automatic check_outputs(input slot_t idx);
      assert (wb_valid == exp_valid[idx]) else begin
         report_mismatch("o_wb_valid", word_t'(exp_valid[idx]), word_t'(wb_valid));
      end
      if (exp_valid[idx]) begin
         assert (wb_addr == exp_addr[idx]) else begin
            report_mismatch("o_wb_addr", word_t'(exp_addr[idx]), word_t'(wb_addr));
         end
         assert (wb_data == exp_data[idx]) else begin
            report_mismatch("o_wb_data", exp_data[idx], wb_data);
         end
         outstanding--;
      end
   endtask

   initial begin
      int waited;
      int drained;
      rng_state   = 32'd99299;
      cycle       = 0;
      outstanding = 0;
      n_writes    = 0;
      for (int i = 0; i < mips_lite_pkg::N_REGS; i++) begin
         model_regs[i] = '0;
      end
      for (int i = 0; i < DEPTH; i++) begin
         exp_valid[i] = 1'b0;
         exp_addr[i]  = '0;
         exp_data[i]  = '0;
      end
      instr_valid <= 1'b0;
      instr       <= '0;

      waited = 0;
      do begin
         @(negedge clock);
         waited++;
      end while (reset !== 1'b0 && waited <= RESET_TIMEOUT);
      if (reset !== 1'b0) begin
         report_timeout("reset was never released");
      end

      // Slot issued LATENCY cycles ago is checked at the falling edge
      for (int n = 0; n < N_SLOTS; n++) begin
         @(posedge clock);
         issue_slot(1'b1);
         @(negedge clock);
         check_outputs(slot_t'((cycle + DEPTH - LATENCY) % DEPTH));
      end

      drained = 0;
      while ((outstanding > 0 || drained < LATENCY) && drained < DRAIN_TIMEOUT) begin
         @(posedge clock);
         issue_slot(1'b0);
         @(negedge clock);
         check_outputs(slot_t'((cycle + DEPTH - LATENCY) % DEPTH));
         drained++;
      end

      if (outstanding > 0) begin
         report_timeout("pipeline did not drain its pending writes");
      end else begin
         $display("%0d slots issued, %0d register writes checked", cycle, n_writes);
         $display("all tests passed");
         $finish;
      end
   end

endmodule
